// File: logic/lockstep_config.svh
////////////////////////////////////////////////////////////
// Build-time widths and lockstep offset for the checker
// Derived widths of the flattened core bundles
////////////////////////////////////////////////////////////

`ifndef LOCKSTEP_CONFIG_SVH
`define LOCKSTEP_CONFIG_SVH

// Cycles the shadow core trails the main core, at least 2
`define LOCKSTEP_OFFSET 2

// Accumulator and command operand width
`define DATA_W 32

// Store address counter width
`define ADDR_W 8

// Opcode width
`define OP_W 2

// Command bundle: strobe, opcode, operand
`define LOCKSTEP_IN_W (1 + `OP_W + `DATA_W)

// Output bundle: store valid, store address, store data, accumulator
`define LOCKSTEP_OUT_W (1 + `ADDR_W + 2 * `DATA_W)

`endif

// File: logic/lockstep_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the lockstep checker
// Data, address and opcode definitions
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

package lockstep_pkg;

  //////////////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////////////

  // Accumulator value or command operand
  typedef logic [`DATA_W-1:0] data_t;

  // Store address, wraps at the top
  typedef logic [`ADDR_W-1:0] addr_t;

  //////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////

  typedef enum logic [`OP_W-1:0] {
    OP_ADD   = `OP_W'(0),
    OP_XOR   = `OP_W'(1),
    OP_CLR   = `OP_W'(2),
    OP_STORE = `OP_W'(3)
  } cmd_op_e;

endpackage

`default_nettype wire

// File: logic/lockstep_delay.sv
////////////////////////////////////////////////////////////
// Reset-cleared shift register for flattened bundles
// Delay of Depth cycles on a Width-bit vector
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module lockstep_delay #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  // Stage 0 takes the input, the last stage drives the output
  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

`default_nettype wire

// File: logic/acc_core.sv
////////////////////////////////////////////////////////////
// Accumulator core with a registered store port
// Runs as the shadow copy inside the lockstep checker
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module acc_core
  import lockstep_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,

  // Command strobe, one cycle per command
  input  logic    cmd_valid_i,
  input  cmd_op_e cmd_op_i,
  input  data_t   cmd_data_i,

  // Store port and accumulator view
  output logic    wr_valid_o,
  output addr_t   wr_addr_o,
  output data_t   wr_data_o,
  output data_t   acc_o
);

  data_t acc_d, acc_q;
  addr_t addr_d, addr_q;
  logic  store;

  logic  wr_valid_q;
  addr_t wr_addr_q;
  data_t wr_data_q;

  //////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////

  always_comb begin
    acc_d  = acc_q;
    addr_d = addr_q;
    store  = 1'b0;
    if (cmd_valid_i) begin
      unique case (cmd_op_i)
        OP_ADD:   acc_d = acc_q + cmd_data_i;
        OP_XOR:   acc_d = acc_q ^ cmd_data_i;
        OP_CLR:   acc_d = '0;
        OP_STORE: begin
          store  = 1'b1;
          // Address counter wraps naturally
          addr_d = addr_q + addr_t'(1);
        end
        default:  acc_d = acc_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////
  // State and store port registers
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q      <= '0;
      addr_q     <= '0;
      wr_valid_q <= 1'b0;
      wr_addr_q  <= '0;
      wr_data_q  <= '0;
    end else begin
      acc_q      <= acc_d;
      addr_q     <= addr_d;
      wr_valid_q <= store;
      // Store port holds the last write between stores
      if (store) begin
        wr_addr_q <= addr_q;
        wr_data_q <= acc_q;
      end
    end
  end

  assign wr_valid_o = wr_valid_q;
  assign wr_addr_o  = wr_addr_q;
  assign wr_data_o  = wr_data_q;
  assign acc_o      = acc_q;

endmodule

`default_nettype wire

// File: logic/lockstep_rst_ctrl.sv
////////////////////////////////////////////////////////////
// Reset sequencing for the shadow core
// Post-reset counter, shadow reset release, compare enable
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module lockstep_rst_ctrl
  import lockstep_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,

  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned Offset = `LOCKSTEP_OFFSET;
  localparam int unsigned CntW   = $clog2(Offset);

  // Counter stops here, one edge before the shadow is released
  localparam logic [CntW-1:0] CntMax = CntW'(Offset - 1);

  logic [CntW-1:0] cnt_q;
  logic            release_d, release_q;
  logic            cmp_en_q;

  //////////////////////////////////////////////////////////
  // Saturating post-reset counter
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CntMax) begin
      cnt_q <= cnt_q + CntW'(1);
    end
  end

  assign release_d = (cnt_q == CntMax);

  //////////////////////////////////////////////////////////
  // Release and enable flags
  //////////////////////////////////////////////////////////

  // Shadow reset drops synchronously, compare follows one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      release_q <= release_d;
      cmp_en_q  <= release_q;
    end
  end

  assign shadow_rst_no = release_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

`default_nettype wire

// File: logic/lockstep_cmp.sv
////////////////////////////////////////////////////////////
// Shadow output register and gated bundle comparator
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module lockstep_cmp
  import lockstep_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       cmp_en_i,
  input  logic [`LOCKSTEP_OUT_W-1:0] shadow_out_i,
  input  logic [`LOCKSTEP_OUT_W-1:0] core_out_i,

  output logic                       alert_o
);

  logic [`LOCKSTEP_OUT_W-1:0] shadow_out_q;
  logic                       mismatch;

  // Extra stage on the shadow side, matched by one more cycle
  // on the main core delay line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_i;
    end
  end

  assign mismatch = (shadow_out_q != core_out_i);

  // Any differing bit raises the alert once compare is enabled
  assign alert_o = cmp_en_i & mismatch;

endmodule

`default_nettype wire

// File: logic/lockstep_top.sv
////////////////////////////////////////////////////////////
// Lockstep checker top level
// Shadow accumulator core, delay lines, reset sequencing
// and the output comparator
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module lockstep_top
  import lockstep_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,

  // Commands seen by the main core
  input  logic    cmd_valid_i,
  input  cmd_op_e cmd_op_i,
  input  data_t   cmd_data_i,

  // Outputs produced by the main core
  input  logic    core_wr_valid_i,
  input  addr_t   core_wr_addr_i,
  input  data_t   core_wr_data_i,
  input  data_t   core_acc_i,

  output logic    alert_major_o
);

  logic shadow_rst_n;
  logic cmp_en;

  //////////////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////////////

  lockstep_rst_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////
  // Command delay into the shadow core
  //////////////////////////////////////////////////////////

  logic [`LOCKSTEP_IN_W-1:0] cmd_bundle;
  logic [`LOCKSTEP_IN_W-1:0] cmd_bundle_dly;

  logic    shadow_cmd_valid;
  cmd_op_e shadow_cmd_op;
  data_t   shadow_cmd_data;

  // Strobe in the top bit, operand in the low bits
  assign cmd_bundle = {cmd_valid_i, cmd_op_i, cmd_data_i};

  lockstep_delay #(
    .Width (`LOCKSTEP_IN_W),
    .Depth (`LOCKSTEP_OFFSET)
  ) u_cmd_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (cmd_bundle),
    .q_o    (cmd_bundle_dly)
  );

  assign shadow_cmd_valid = cmd_bundle_dly[`LOCKSTEP_IN_W-1];
  assign shadow_cmd_op    = cmd_op_e'(cmd_bundle_dly[`DATA_W +: `OP_W]);
  assign shadow_cmd_data  = cmd_bundle_dly[`DATA_W-1:0];

  //////////////////////////////////////////////////////////
  // Shadow core
  //////////////////////////////////////////////////////////

  logic  shadow_wr_valid;
  addr_t shadow_wr_addr;
  data_t shadow_wr_data;
  data_t shadow_acc;

  acc_core u_shadow_core (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_n),
    .cmd_valid_i (shadow_cmd_valid),
    .cmd_op_i    (shadow_cmd_op),
    .cmd_data_i  (shadow_cmd_data),
    .wr_valid_o  (shadow_wr_valid),
    .wr_addr_o   (shadow_wr_addr),
    .wr_data_o   (shadow_wr_data),
    .acc_o       (shadow_acc)
  );

  //////////////////////////////////////////////////////////
  // Main core output delay and comparison
  //////////////////////////////////////////////////////////

  logic [`LOCKSTEP_OUT_W-1:0] core_bundle;
  logic [`LOCKSTEP_OUT_W-1:0] core_bundle_dly;
  logic [`LOCKSTEP_OUT_W-1:0] shadow_bundle;

  // Both bundles share one field order
  assign core_bundle   = {core_wr_valid_i, core_wr_addr_i, core_wr_data_i, core_acc_i};
  assign shadow_bundle = {shadow_wr_valid, shadow_wr_addr, shadow_wr_data, shadow_acc};

  // One cycle longer to cover the shadow output register
  lockstep_delay #(
    .Width (`LOCKSTEP_OUT_W),
    .Depth (`LOCKSTEP_OFFSET + 1)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (core_bundle),
    .q_o    (core_bundle_dly)
  );

  lockstep_cmp u_cmp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .shadow_out_i (shadow_bundle),
    .core_out_i   (core_bundle_dly),
    .alert_o      (alert_major_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_lockstep_top.sv
////////////////////////////////////////////////////////////
// Testbench for the lockstep checker
// Main core reference model, fault injection, alert
// assertions, watchdog and summary
////////////////////////////////////////////////////////////

`default_nettype none

`include "lockstep_config.svh"

module tb_lockstep_top
  import lockstep_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int Offset       = `LOCKSTEP_OFFSET;
  localparam int ClkPeriod    = 8;
  localparam int RstCycles    = 3;
  localparam int GapCycles    = Offset + 4;
  localparam int RandCycles   = 600;
  localparam int StoreFaults  = 4;
  localparam int FieldRepeats = 2;

  // Which main output a fault hits
  localparam int FieldNone  = 0;
  localparam int FieldValid = 1;
  localparam int FieldAddr  = 2;
  localparam int FieldData  = 3;
  localparam int FieldAcc   = 4;

  // Cycle budget per test, summed for the watchdog
  localparam int ResetLen  = RstCycles + 1;
  localparam int Test1Len  = ResetLen + 1 + GapCycles;
  localparam int Test3Len  = StoreFaults * (3 + GapCycles);
  localparam int Test4Len  = 3 * FieldRepeats * (2 + GapCycles);
  localparam int Test5Len  = 23 + ResetLen + 12 + GapCycles;
  localparam int TotalLen  = Test1Len + RandCycles + Test3Len + Test4Len + Test5Len;
  localparam int TimeoutNs = (TotalLen + 100) * ClkPeriod;

  logic    clk_i;
  logic    rst_ni;
  logic    cmd_valid_i;
  cmd_op_e cmd_op_i;
  data_t   cmd_data_i;
  logic    core_wr_valid_i;
  addr_t   core_wr_addr_i;
  data_t   core_wr_data_i;
  data_t   core_acc_i;
  logic    alert_major_o;

  // Main core model state
  data_t m_acc;
  addr_t m_addr;
  logic  m_wr_valid;
  addr_t m_wr_addr;
  data_t m_wr_data;

  logic        fault_now;
  int          edges_since_rst;
  int          errors;
  int          tests_done;
  int          faults_in_test;
  int          alerts_in_test;
  logic [31:0] rng_state;

  lockstep_top dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_op_i        (cmd_op_i),
    .cmd_data_i      (cmd_data_i),
    .core_wr_valid_i (core_wr_valid_i),
    .core_wr_addr_i  (core_wr_addr_i),
    .core_wr_data_i  (core_wr_data_i),
    .core_acc_i      (core_acc_i),
    .alert_major_o   (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////
  // Main core reference model
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_acc      <= '0;
      m_addr     <= '0;
      m_wr_valid <= 1'b0;
      m_wr_addr  <= '0;
      m_wr_data  <= '0;
    end else begin
      m_wr_valid <= 1'b0;
      if (cmd_valid_i) begin
        case (cmd_op_i)
          OP_ADD:   m_acc <= m_acc + cmd_data_i;
          OP_XOR:   m_acc <= m_acc ^ cmd_data_i;
          OP_CLR:   m_acc <= '0;
          OP_STORE: begin
            // Store port keeps the last write until the next store
            m_wr_valid <= 1'b1;
            m_wr_addr  <= m_addr;
            m_wr_data  <= m_acc;
            m_addr     <= m_addr + addr_t'(1);
          end
          default:  m_acc <= m_acc;
        endcase
      end
    end
  end

  // Edges since reset release, saturating past the enable window
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges_since_rst <= 0;
    end else if (edges_since_rst <= Offset) begin
      edges_since_rst <= edges_since_rst + 1;
    end
  end

  //////////////////////////////////////////////////////////
  // Alert assertions
  //////////////////////////////////////////////////////////

  in_reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !alert_major_o)
    else begin
      errors++;
      $display("Fail at %0t: alert high while reset is asserted", $time);
    end

  enable_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (edges_since_rst <= Offset) |-> !alert_major_o)
    else begin
      errors++;
      $display("Fail at %0t: alert high inside the enable window", $time);
    end

  // Alert mirrors a fault Offset + 1 cycles later and nothing else
  alert_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (edges_since_rst > Offset) |-> (alert_major_o == $past(fault_now, Offset + 1)))
    else begin
      errors++;
      $display("Fail at %0t: alert does not match the fault %0d cycles earlier", $time,
               Offset + 1);
    end

  //////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic drive_inputs(input logic valid, input cmd_op_e op, input data_t data,
                              input int field, input int unsigned bit_idx);
    addr_t addr_flip;
    data_t wdata_flip;
    data_t acc_flip;
    addr_flip  = (field == FieldAddr) ? addr_t'(1) << bit_idx : '0;
    wdata_flip = (field == FieldData) ? data_t'(1) << bit_idx : '0;
    acc_flip   = (field == FieldAcc) ? data_t'(1) << bit_idx : '0;
    cmd_valid_i     = valid;
    cmd_op_i        = op;
    cmd_data_i      = data;
    core_wr_valid_i = m_wr_valid ^ (field == FieldValid);
    core_wr_addr_i  = m_wr_addr ^ addr_flip;
    core_wr_data_i  = m_wr_data ^ wdata_flip;
    core_acc_i      = m_acc ^ acc_flip;
    fault_now       = (field != FieldNone);
    if (fault_now && rst_ni) faults_in_test++;
  endtask

  // Alert is sampled before the new inputs go out
  task automatic drive_cycle(input logic valid, input cmd_op_e op, input data_t data,
                             input int field, input int unsigned bit_idx);
    @(negedge clk_i);
    if (alert_major_o) alerts_in_test++;
    drive_inputs(valid, op, data, field, bit_idx);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) drive_cycle(1'b0, OP_ADD, '0, FieldNone, 0);
  endtask

  task automatic run_random(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = next_rand();
      drive_cycle(r[1:0] != 2'b00, cmd_op_e'(r[3:2]), next_rand(), FieldNone, 0);
    end
  endtask

  task automatic inject(input int field);
    int unsigned width;
    int unsigned bit_idx;
    width   = (field == FieldAddr) ? `ADDR_W : `DATA_W;
    bit_idx = next_rand() % width;
    drive_cycle(1'b0, OP_ADD, '0, field, bit_idx);
  endtask

  task automatic store_then_corrupt();
    drive_cycle(1'b1, OP_ADD, next_rand(), FieldNone, 0);
    drive_cycle(1'b1, OP_STORE, '0, FieldNone, 0);
    inject(FieldData);
  endtask

  // Main outputs carry the given fault for the whole reset and at the
  // first edge after release, which also takes a command
  task automatic apply_reset(input int field);
    @(negedge clk_i);
    if (alert_major_o) alerts_in_test++;
    rst_ni = 1'b0;
    drive_inputs(1'b0, OP_ADD, '0, field, 0);
    #1;
    reset_drop: assert (alert_major_o == 1'b0)
      else begin
        errors++;
        $display("Fail at %0t: alert did not drop when reset was asserted", $time);
      end
    repeat (RstCycles - 1) drive_cycle(1'b0, OP_ADD, '0, field, 0);
    @(negedge clk_i);
    rst_ni = 1'b1;
    drive_inputs(1'b1, OP_ADD, next_rand(), field, 0);
  endtask

  task automatic end_test(input string name);
    alert_count: assert (alerts_in_test == faults_in_test)
      else begin
        errors++;
        $display("Fail at %0t: %s saw %0d alert cycles for %0d faults", $time, name,
                 alerts_in_test, faults_in_test);
      end
    $display("%s: done, %0d faults, %0d alert cycles", name, faults_in_test,
             alerts_in_test);
    tests_done++;
    faults_in_test = 0;
    alerts_in_test = 0;
  endtask

  //////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_op_i        = OP_ADD;
    cmd_data_i      = '0;
    core_wr_valid_i = 1'b0;
    core_wr_addr_i  = '0;
    core_wr_data_i  = '0;
    core_acc_i      = '0;
    fault_now       = 1'b0;
    errors          = 0;
    tests_done      = 0;
    faults_in_test  = 0;
    alerts_in_test  = 0;
    rng_state       = 32'h2b00;

    apply_reset(FieldAcc);
    inject(FieldAcc);
    idle(GapCycles);
    end_test("reset window");

    run_random(RandCycles);
    end_test("random stream");

    repeat (StoreFaults) begin
      store_then_corrupt();
      idle(GapCycles);
    end
    end_test("store data fault");

    for (int field = FieldValid; field <= FieldAcc; field++) begin
      if (field != FieldData) begin
        repeat (FieldRepeats) begin
          run_random(1);
          inject(field);
          idle(GapCycles);
        end
      end
    end
    end_test("valid addr acc faults");

    // Reset lands while the alert of an earlier fault is high
    run_random(20);
    inject(FieldAcc);
    idle(Offset);
    apply_reset(FieldData);
    run_random(9);
    store_then_corrupt();
    idle(GapCycles);
    end_test("mid-run reset");

    $display("Summary: %0d tests run, %0d errors", tests_done, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired: tests did not finish within %0d ns", TimeoutNs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/lockstep_pkg.sv
logic/lockstep_delay.sv
logic/acc_core.sv
logic/lockstep_rst_ctrl.sv
logic/lockstep_cmp.sv
logic/lockstep_top.sv
dv/tb_lockstep_top.sv

// File: Makefile
# Verilator simulation of the lockstep checker

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_lockstep_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the pass line appears in the simulation output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
